/* src/icache_pkg.sv */
package icache_pkg;

    // cache geometry.
    localparam int num_ways       = 4;
    localparam int num_sets       = 64;
    localparam int words_per_line = 4;
    localparam int tag_w          = 22;
    localparam int index_w        = 6;
    localparam int offset_w       = 4;

    // byte address as seen by the cache.
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [index_w-1:0]  index;
        logic [offset_w-1:0] offset;
    } addr_t;

    typedef logic [num_ways-1:0] way_t; // one-hot way vector.

    typedef logic [words_per_line-1:0][31:0] line_t;

    typedef struct packed {
        logic [31:0] addr;
    } fetch_req_t;

    // line read request with a line aligned address.
    typedef struct packed {
        logic [31:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;
    } mem_rd_beat_t;

endpackage

/* src/icache_main_fsm.sv */
module icache_main_fsm (
    input  logic             clk,
    input  logic             rstn,
    input  logic             valid,
    input  logic             cache_hit,
    input  logic             r_rdy_AXI,
    input  logic             fill_finish,
    input  icache_pkg::way_t lru_way_sel,
    input  icache_pkg::way_t hit,
    output icache_pkg::way_t way_visit,
    output logic             mbuf_we,
    output logic             rdata_sel,
    output logic             rbuf_we,
    output logic             way_sel_en,
    output icache_pkg::way_t mem_we,
    output icache_pkg::way_t tagv_we,
    output logic             r_req,
    output logic             r_data_ready,
    output logic             data_valid,
    output logic             cache_ready
);
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_replace,
        st_refill
    } state_t;

    state_t state;
    state_t state_nxt;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                if (valid) state_nxt = st_lookup;
            end
            st_lookup: begin
                if (!cache_hit) begin
                    state_nxt = st_replace;
                end else if (!valid) begin
                    state_nxt = st_idle; // hit with nothing queued behind it.
                end
            end
            st_replace: begin
                if (r_rdy_AXI) state_nxt = st_refill;
            end
            st_refill: begin
                if (fill_finish) state_nxt = valid ? st_lookup : st_idle;
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_comb begin
        mbuf_we      = 1'b0;
        rbuf_we      = 1'b0;
        rdata_sel    = 1'b0;
        way_sel_en   = 1'b0;
        r_req        = 1'b0;
        r_data_ready = 1'b0;
        data_valid   = 1'b0;
        cache_ready  = 1'b0;
        way_visit    = '0;
        mem_we       = '0;
        tagv_we      = '0;
        case (state)
            st_idle: begin
                rbuf_we     = 1'b1;
                cache_ready = 1'b1;
            end
            st_lookup: begin
                rdata_sel = 1'b1; // word comes from the hit way.
                if (cache_hit) begin
                    data_valid  = 1'b1;
                    rbuf_we     = 1'b1;
                    cache_ready = 1'b1;
                    way_visit   = hit;
                    way_sel_en  = 1'b1;
                end else begin
                    mbuf_we = 1'b1;
                end
            end
            st_replace: begin
                r_req = 1'b1;
            end
            st_refill: begin
                r_data_ready = 1'b1;
                // line is complete so commit it to the victim and answer.
                if (fill_finish) begin
                    mem_we      = lru_way_sel;
                    tagv_we     = lru_way_sel;
                    way_visit   = lru_way_sel;
                    way_sel_en  = 1'b1;
                    data_valid  = 1'b1;
                    rbuf_we     = 1'b1;
                    cache_ready = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

/* src/icache_lookup.sv */
module icache_lookup (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   rbuf_we,
    input  icache_pkg::fetch_req_t req,
    input  icache_pkg::way_t       tagv_we,
    output icache_pkg::addr_t      rbuf,
    output icache_pkg::way_t       hit,
    output logic                   cache_hit
);
    import icache_pkg::*;

    logic [tag_w-1:0]    tag_mem [num_ways][num_sets];
    logic [num_sets-1:0] valid_q [num_ways];

    // request buffer.
    always_ff @(posedge clk) begin
        if (rbuf_we) rbuf <= addr_t'(req.addr);
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (tagv_we[w]) valid_q[w][rbuf.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (tagv_we[w]) tag_mem[w][rbuf.index] <= rbuf.tag;
        end
    end

    // tag compare on the buffered address.
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w][rbuf.index] && (tag_mem[w][rbuf.index] == rbuf.tag);
        end
    end

    assign cache_hit = |hit;

endmodule

/* src/icache_data_array.sv */
module icache_data_array (
    input  logic              clk,
    input  icache_pkg::addr_t rbuf,
    input  icache_pkg::way_t  mem_we,
    input  icache_pkg::way_t  hit,
    input  icache_pkg::line_t fill_line,
    input  logic              rdata_sel,
    output logic [31:0]       rdata
);
    import icache_pkg::*;

    line_t data_mem [num_ways][num_sets];
    line_t hit_line;
    logic [$clog2(words_per_line)-1:0] word;

    assign word = rbuf.offset[offset_w-1:2]; // drop the byte offset.

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (mem_we[w]) data_mem[w][rbuf.index] <= fill_line;
        end
    end

    // or together the ways flagged in the one-hot hit.
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) hit_line = hit_line | data_mem[w][rbuf.index];
        end
    end

    assign rdata = rdata_sel ? hit_line[word] : fill_line[word];

endmodule

/* src/icache_lru.sv */
module icache_lru (
    input  logic                           clk,
    input  logic                           rstn,
    input  logic                           way_sel_en,
    input  logic [icache_pkg::index_w-1:0] index,
    input  icache_pkg::way_t               way_visit,
    output icache_pkg::way_t               lru_way_sel
);
    import icache_pkg::*;

    // bit 0 picks the pair, bit 1 the left pair, bit 2 the right pair.
    logic [2:0] tree_q [num_sets];
    logic [2:0] cur;
    logic [2:0] tree_nxt;

    assign cur = tree_q[index];

    always_comb begin
        tree_nxt = cur;
        case (way_visit)
            4'b0001: tree_nxt[1:0] = 2'b11;
            4'b0010: tree_nxt[1:0] = 2'b01;
            4'b0100: {tree_nxt[2], tree_nxt[0]} = 2'b10;
            4'b1000: {tree_nxt[2], tree_nxt[0]} = 2'b00;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tree_q <= '{default: '0};
        end else if (way_sel_en) begin
            tree_q[index] <= tree_nxt;
        end
    end

    always_comb begin
        if (!cur[0]) lru_way_sel = cur[1] ? 4'b0010 : 4'b0001;
        else lru_way_sel = cur[2] ? 4'b1000 : 4'b0100;
    end

endmodule

/* src/icache_refill.sv */
module icache_refill (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     mbuf_we,
    input  logic                     r_req,
    input  logic                     r_data_ready,
    input  logic                     ret_valid,
    input  icache_pkg::addr_t        rbuf,
    input  icache_pkg::mem_rd_beat_t ret,
    output logic                     rd_req,
    output logic                     ret_ready,
    output logic                     fill_finish,
    output icache_pkg::mem_rd_req_t  rd_addr,
    output icache_pkg::line_t        fill_line
);
    import icache_pkg::*;

    mem_rd_req_t mbuf;
    logic [$clog2(words_per_line)-1:0] beat_cnt;
    logic beat_take;

    // miss line address.
    always_ff @(posedge clk) begin
        if (mbuf_we) mbuf.addr <= {rbuf.tag, rbuf.index, {offset_w{1'b0}}};
    end

    assign rd_addr = mbuf;
    assign rd_req  = r_req;

    assign ret_ready = r_data_ready & ~fill_finish; // stop once the line is in.
    assign beat_take = ret_valid & ret_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_cnt    <= '0;
            fill_finish <= 1'b0;
        end else begin
            fill_finish <= beat_take & ret.last;
            if (mbuf_we) begin
                beat_cnt <= '0;
            end else if (beat_take) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // beats come in word order.
    always_ff @(posedge clk) begin
        if (beat_take) fill_line[beat_cnt] <= ret.data;
    end

endmodule

/* src/icache_top.sv */
module icache_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     valid,
    input  icache_pkg::fetch_req_t   req,
    output logic                     cache_ready,
    output logic                     data_valid,
    output logic [31:0]              rdata,
    output logic                     rd_req,
    output icache_pkg::mem_rd_req_t  rd_addr,
    input  logic                     rd_rdy,
    input  logic                     ret_valid,
    input  icache_pkg::mem_rd_beat_t ret,
    output logic                     ret_ready
);
    import icache_pkg::*;

    addr_t rbuf;
    way_t  hit;
    way_t  lru_way_sel;
    way_t  way_visit;
    way_t  mem_we;
    way_t  tagv_we;
    line_t fill_line;
    logic  cache_hit;
    logic  fill_finish;
    logic  mbuf_we;
    logic  rdata_sel;
    logic  rbuf_we;
    logic  way_sel_en;
    logic  r_req;
    logic  r_data_ready;

    icache_main_fsm u_fsm (
        .clk          (clk),
        .rstn         (rstn),
        .valid        (valid),
        .cache_hit    (cache_hit),
        .r_rdy_AXI    (rd_rdy),
        .fill_finish  (fill_finish),
        .lru_way_sel  (lru_way_sel),
        .hit          (hit),
        .way_visit    (way_visit),
        .mbuf_we      (mbuf_we),
        .rdata_sel    (rdata_sel),
        .rbuf_we      (rbuf_we),
        .way_sel_en   (way_sel_en),
        .mem_we       (mem_we),
        .tagv_we      (tagv_we),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .data_valid   (data_valid),
        .cache_ready  (cache_ready)
    );

    icache_lookup u_lookup (
        .clk       (clk),
        .rstn      (rstn),
        .rbuf_we   (rbuf_we),
        .req       (req),
        .tagv_we   (tagv_we),
        .rbuf      (rbuf),
        .hit       (hit),
        .cache_hit (cache_hit)
    );

    icache_data_array u_data (
        .clk       (clk),
        .rbuf      (rbuf),
        .mem_we    (mem_we),
        .hit       (hit),
        .fill_line (fill_line),
        .rdata_sel (rdata_sel),
        .rdata     (rdata)
    );

    icache_lru u_lru (
        .clk         (clk),
        .rstn        (rstn),
        .way_sel_en  (way_sel_en),
        .index       (rbuf.index),
        .way_visit   (way_visit),
        .lru_way_sel (lru_way_sel)
    );

    icache_refill u_refill (
        .clk          (clk),
        .rstn         (rstn),
        .mbuf_we      (mbuf_we),
        .r_req        (r_req),
        .r_data_ready (r_data_ready),
        .ret_valid    (ret_valid),
        .rbuf         (rbuf),
        .ret          (ret),
        .rd_req       (rd_req),
        .ret_ready    (ret_ready),
        .fill_finish  (fill_finish),
        .rd_addr      (rd_addr),
        .fill_line    (fill_line)
    );

endmodule

/* verif/icache_mem_model.sv */
module icache_mem_model (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     stall_en,
    input  logic                     rd_req,
    input  icache_pkg::mem_rd_req_t  rd_addr,
    output logic                     rd_rdy,
    output logic                     ret_valid,
    output icache_pkg::mem_rd_beat_t ret,
    input  logic                     ret_ready,
    output int                       req_count
);
    import icache_pkg::*;

    integer seed = 32'h746053b7;
    logic [31:0] line;

    // 0 to 3 idle cycles when stalls are on.
    function automatic int pick_delay();
        if (!stall_en) return 0;
        return $unsigned($random(seed)) % 4;
    endfunction

    task automatic skip_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret       = '0;
        req_count = 0;
        forever begin
            @(negedge clk);
            if (rstn && rd_req) begin
                line = rd_addr.addr;
                @(posedge clk);
                #1;
                skip_cycles(pick_delay());
                rd_rdy = 1'b1;
                @(posedge clk); // request taken here.
                #1;
                rd_rdy = 1'b0;
                req_count++;
                for (int b = 0; b < words_per_line; b++) begin
                    skip_cycles(pick_delay());
                    ret_valid = 1'b1;
                    ret.data  = ~((line >> 2) + b);
                    ret.last  = (b == words_per_line - 1);
                    @(negedge clk);
                    while (!ret_ready) @(negedge clk);
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                end
            end
        end
    end

endmodule

/* verif/icache_tb.sv */
module icache_tb;
    import icache_pkg::*;

    localparam int total_fetches = 28;
    localparam int cycles_per_fetch = 40;

    logic         clk = 1'b0;
    logic         rstn;
    logic         valid;
    fetch_req_t   req;
    logic         cache_ready;
    logic         data_valid;
    logic [31:0]  rdata;
    logic         rd_req;
    mem_rd_req_t  rd_addr;
    logic         rd_rdy;
    logic         ret_valid;
    mem_rd_beat_t ret;
    logic         ret_ready;
    logic         stall_en;
    int           req_count;
    int           errors = 0;
    int           checks = 0;
    bit           req_pending = 1'b0;
    logic [31:0]  stream[$]; // addresses of the next fetch sequence.

    always #50 clk = ~clk;

    icache_top uut (
        .clk         (clk),
        .rstn        (rstn),
        .valid       (valid),
        .req         (req),
        .cache_ready (cache_ready),
        .data_valid  (data_valid),
        .rdata       (rdata),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_rdy      (rd_rdy),
        .ret_valid   (ret_valid),
        .ret         (ret),
        .ret_ready   (ret_ready)
    );

    icache_mem_model u_mem (
        .clk       (clk),
        .rstn      (rstn),
        .stall_en  (stall_en),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret       (ret),
        .ret_ready (ret_ready),
        .req_count (req_count)
    );

    // a line request must stay up until the memory takes it.
    always @(negedge clk) begin
        if (rstn && req_pending && !rd_req) begin
            errors++;
            $display("rd_req dropped before the memory accepted it");
        end
        req_pending = rd_req && !rd_rdy;
    end

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        return ~(a >> 2);
    endfunction

    function automatic logic [31:0] line_addr(input logic [21:0] tag, input logic [5:0] index,
                                              input logic [1:0] word);
        return {tag, index, word, 2'b00};
    endfunction

    // distinct lines in the current fetch sequence.
    function automatic int count_lines();
        int n;
        bit dup;
        n = 0;
        for (int i = 0; i < stream.size(); i++) begin
            dup = 1'b0;
            for (int j = 0; j < i; j++) begin
                if (stream[j][31:4] == stream[i][31:4]) dup = 1'b1;
            end
            if (!dup) n++;
        end
        return n;
    endfunction

    task automatic queue_fetch(input logic [21:0] tag, input logic [5:0] index,
                               input logic [1:0] word);
        stream.push_back(line_addr(tag, index, word));
    endtask

    task automatic check_requests(input string name, input int start, input int expected);
        checks++;
        if (req_count - start != expected) begin
            errors++;
            $display("FAILED %s requests: expected %0d, actual %0d",
                     name, expected, req_count - start);
        end
    endtask

    // holds valid and moves to the next address at each acceptance.
    task automatic run_stream(input string name, input bit all_hits);
        logic [31:0] pend[$];
        int          acc_cyc[$];
        logic [31:0] want;
        int          cyc;
        int          sent;
        int          got;
        int          lat;
        bit          accept;
        bit          hung;
        cyc = 0;
        sent = 0;
        got = 0;
        hung = 1'b0;
        valid = 1'b1;
        req.addr = stream[0];
        while (got < stream.size() && !hung) begin
            @(negedge clk);
            cyc++;
            if (rd_req && pend.size() != 0 && rd_addr.addr !== {pend[0][31:4], 4'b0000}) begin
                errors++;
                $display("FAILED %s line address: expected %h, actual %h",
                         name, {pend[0][31:4], 4'b0000}, rd_addr.addr);
            end
            if (data_valid) begin
                if (pend.size() == 0) begin
                    errors++;
                    $display("%s: data_valid with no request outstanding", name);
                end else begin
                    want = mem_word(pend.pop_front());
                    lat = cyc - acc_cyc.pop_front();
                    got++;
                    checks++;
                    if (rdata !== want) begin
                        errors++;
                        $display("FAILED %s: expected %h, actual %h", name, want, rdata);
                    end
                    if (all_hits && lat != 1) begin
                        errors++;
                        $display("FAILED %s latency: expected 1, actual %0d", name, lat);
                    end
                end
            end
            accept = valid && cache_ready;
            if (accept) begin
                pend.push_back(req.addr);
                acc_cyc.push_back(cyc);
                sent++;
            end
            if (cyc > stream.size() * cycles_per_fetch) begin
                hung = 1'b1;
                errors++;
                $display("%s: handshake hang, the cache stopped answering", name);
            end
            @(posedge clk);
            #1;
            if (accept) begin
                if (sent < stream.size()) req.addr = stream[sent];
                else valid = 1'b0;
            end
        end
        valid = 1'b0;
        if (all_hits && !hung && cyc != stream.size() + 1) begin
            errors++;
            $display("FAILED %s cycles: expected %0d, actual %0d", name, stream.size() + 1, cyc);
        end
    endtask

    task automatic fetch_and_count(input string name, input logic [21:0] tag,
                                   input logic [5:0] index, input logic [1:0] word,
                                   input int start, input int total);
        stream.delete();
        queue_fetch(tag, index, word);
        run_stream(name, 1'b0);
        check_requests(name, start, total);
    endtask

    task automatic after_reset_fill();
        int start;
        start = req_count;
        @(negedge clk);
        checks++;
        if ({cache_ready, data_valid, rd_req, ret_ready} !== 4'b1000) begin
            errors++;
            $display("FAILED after_reset: expected 1000, actual %b",
                     {cache_ready, data_valid, rd_req, ret_ready});
        end
        @(posedge clk);
        #1;
        fetch_and_count("after_reset", 5, 3, 2, start, 1);
    endtask

    task automatic hit_same_line();
        int start;
        start = req_count;
        stream.delete();
        queue_fetch(5, 3, 0);
        queue_fetch(5, 3, 1);
        queue_fetch(5, 3, 3);
        run_stream("hits", 1'b1);
        check_requests("hits", start, 0);
    endtask

    task automatic misses_under_stall();
        int start;
        start = req_count;
        stall_en = 1'b1;
        stream.delete();
        queue_fetch(7, 10, 1);
        queue_fetch(7, 11, 2);
        queue_fetch(9, 12, 0);
        queue_fetch(7, 10, 3);
        queue_fetch(3, 13, 3);
        queue_fetch(9, 12, 2);
        run_stream("stalls", 1'b0);
        check_requests("stalls", start, 4);
        stall_en = 1'b0;
    endtask

    task automatic replacement_order();
        int start;
        start = req_count;
        for (int t = 1; t <= 5; t++) begin
            fetch_and_count("replace", t, 20, t % 4, start, t);
        end
        // E took A's way, and A then takes B's, the oldest line by then.
        fetch_and_count("replace_a", 1, 20, 0, start, 6);
        fetch_and_count("replace_b", 2, 20, 1, start, 7);
        fetch_and_count("replace_a_hit", 1, 20, 3, start, 7);
    endtask

    task automatic mixed_stream();
        int start;
        start = req_count;
        stall_en = 1'b1;
        stream.delete();
        queue_fetch(1, 30, 0);
        queue_fetch(1, 31, 1);
        queue_fetch(1, 30, 2);
        queue_fetch(2, 30, 3);
        queue_fetch(1, 31, 0);
        queue_fetch(4, 32, 1);
        queue_fetch(2, 30, 1);
        queue_fetch(3, 31, 3);
        queue_fetch(4, 32, 3);
        queue_fetch(1, 30, 1);
        run_stream("mixed", 1'b0);
        check_requests("mixed", start, count_lines());
        stall_en = 1'b0;
    endtask

    initial begin
        #((total_fetches * cycles_per_fetch + 2) * 100);
        $display("watchdog expired before the tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        rstn     = 1'b0;
        valid    = 1'b0;
        req      = '0;
        stall_en = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rstn = 1'b1;
        after_reset_fill();
        hit_same_line();
        misses_under_stall();
        replacement_order();
        mixed_stream();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* icache_top.f */
src/icache_pkg.sv
src/icache_main_fsm.sv
src/icache_lookup.sv
src/icache_data_array.sv
src/icache_lru.sv
src/icache_refill.sv
src/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv
